/* design/alarm_unit.sv */
`timescale 1ns/1ps

module alarm_unit
	import clock_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  field_mask_t i_inc,
	input  logic        i_alarm_en,
	input  field_t      i_sec,
	input  field_t      i_min,
	input  field_t      i_hou,
	output field_t      o_alarm_sec,
	output field_t      o_alarm_min,
	output field_t      o_alarm_hou,
	output logic        o_alarm
);

	logic match;

	// ------------------------------
	// Alarm time
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_sec <= '0;
			o_alarm_min <= '0;
			o_alarm_hou <= '0;
		end else begin
			if (i_inc[0])
				o_alarm_sec <= field_step(o_alarm_sec, SEC_MAX);
			if (i_inc[1])
				o_alarm_min <= field_step(o_alarm_min, MIN_MAX);
			if (i_inc[2])
				o_alarm_hou <= field_step(o_alarm_hou, HOU_MAX);
		end
	end

	// All three fields agree
	assign match = (i_sec == o_alarm_sec) &&
	               (i_min == o_alarm_min) &&
	               (i_hou == o_alarm_hou);

	// ------------------------------
	// Alarm level
	// ------------------------------
	// Set on match, held until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else if (!i_alarm_en) begin
			o_alarm <= 1'b0;
		end else if (match) begin
			o_alarm <= 1'b1;
		end
	end

endmodule

/* design/clock_pkg.sv */
package clock_pkg;

	// ------------------------------
	// Field widths
	// ------------------------------
	typedef logic [5:0] field_t;

	// Bit 0 seconds, bit 1 minutes, bit 2 hours
	typedef logic [2:0] field_mask_t;

	// Segments a..g, a is the MSB, active high
	typedef logic [6:0] seg_t;

	// ------------------------------
	// Field limits
	// ------------------------------
	localparam int SEC_MAX    = 59;
	localparam int MIN_MAX    = 59;
	localparam int HOU_MAX    = 23;
	localparam int NUM_DIGITS = 6;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HOU = 2'd2
	} pos_t;

	// One step of a field, back to zero after its last value
	function automatic field_t field_step(input field_t value, input int max);
		field_t next;
		if (value == field_t'(max))
			next = '0;
		else
			next = value + field_t'(1);
		return next;
	endfunction

endpackage

/* design/clock_top.sv */
`timescale 1ns/1ps

module clock_top
	import clock_pkg::*;
#(
	parameter int TICK_DIV = 50_000_000,
	parameter int SCAN_DIV = 5_000
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_sw_mode,
	input  logic                  i_sw_pos,
	input  logic                  i_sw_inc,
	input  logic                  i_sw_alarm,
	output seg_t                  o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_seg_dp,
	output logic                  o_alarm
);

	logic        sec_tick;
	mode_t       mode;
	pos_t        position;
	logic        alarm_en;
	logic        run;
	field_mask_t time_inc;
	field_mask_t alarm_inc;
	field_t      sec;
	field_t      min;
	field_t      hou;
	field_t      alarm_sec;
	field_t      alarm_min;
	field_t      alarm_hou;

	// ------------------------------
	// Seconds tick and controls
	// ------------------------------
	tick_gen #(
		.DIV (TICK_DIV)
	) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	key_ctrl u_key_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sw_mode   (i_sw_mode),
		.i_sw_pos    (i_sw_pos),
		.i_sw_inc    (i_sw_inc),
		.i_sw_alarm  (i_sw_alarm),
		.o_mode      (mode),
		.o_position  (position),
		.o_alarm_en  (alarm_en),
		.o_run       (run),
		.o_time_inc  (time_inc),
		.o_alarm_inc (alarm_inc)
	);

	// ------------------------------
	// Counters, alarm and display
	// ------------------------------
	time_counter u_time_counter (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (sec_tick),
		.i_run  (run),
		.i_inc  (time_inc),
		.o_sec  (sec),
		.o_min  (min),
		.o_hou  (hou)
	);

	alarm_unit u_alarm_unit (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_inc       (alarm_inc),
		.i_alarm_en  (alarm_en),
		.i_sec       (sec),
		.i_min       (min),
		.i_hou       (hou),
		.o_alarm_sec (alarm_sec),
		.o_alarm_min (alarm_min),
		.o_alarm_hou (alarm_hou),
		.o_alarm     (o_alarm)
	);

	seg_display #(
		.SCAN_DIV (SCAN_DIV)
	) u_seg_display (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_mode      (mode),
		.i_position  (position),
		.i_sec       (sec),
		.i_min       (min),
		.i_hou       (hou),
		.i_alarm_sec (alarm_sec),
		.i_alarm_min (alarm_min),
		.i_alarm_hou (alarm_hou),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb),
		.o_seg_dp    (o_seg_dp)
	);

endmodule

/* design/key_ctrl.sv */
`timescale 1ns/1ps

module key_ctrl
	import clock_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_sw_mode,
	input  logic        i_sw_pos,
	input  logic        i_sw_inc,
	input  logic        i_sw_alarm,
	output mode_t       o_mode,
	output pos_t        o_position,
	output logic        o_alarm_en,
	output logic        o_run,
	output field_mask_t o_time_inc,
	output field_mask_t o_alarm_inc
);

	localparam int SW_MODE  = 0;
	localparam int SW_POS   = 1;
	localparam int SW_INC   = 2;
	localparam int SW_ALARM = 3;

	logic [3:0]  sw_in;
	logic [3:0]  sw_meta;
	logic [3:0]  sw_sync;
	logic [3:0]  sw_last;
	logic [3:0]  press;
	field_mask_t pos_mask;

	assign sw_in = {i_sw_alarm, i_sw_inc, i_sw_pos, i_sw_mode};

	// ------------------------------
	// Synchronizers and edge detect
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sw_meta <= '0;
			sw_sync <= '0;
			sw_last <= '0;
		end else begin
			sw_meta <= sw_in;
			sw_sync <= sw_meta;
			sw_last <= sw_sync;
		end
	end

	assign press = sw_sync & ~sw_last;

	// ------------------------------
	// User configuration
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= MODE_CLOCK;
			o_position <= POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (press[SW_MODE]) begin
				case (o_mode)
					MODE_CLOCK: o_mode <= MODE_SETUP;
					MODE_SETUP: o_mode <= MODE_ALARM;
					default:    o_mode <= MODE_CLOCK;
				endcase
			end
			if (press[SW_POS]) begin
				case (o_position)
					POS_SEC: o_position <= POS_MIN;
					POS_MIN: o_position <= POS_HOU;
					default: o_position <= POS_SEC;
				endcase
			end
			if (press[SW_ALARM])
				o_alarm_en <= ~o_alarm_en;
		end
	end

	// Increment goes to the field under the cursor
	assign pos_mask = field_mask_t'(1) << o_position;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time_inc  <= '0;
			o_alarm_inc <= '0;
		end else begin
			o_time_inc  <= (press[SW_INC] && o_mode == MODE_SETUP) ? pos_mask : '0;
			o_alarm_inc <= (press[SW_INC] && o_mode == MODE_ALARM) ? pos_mask : '0;
		end
	end

	// Clock stops only while setting the time
	assign o_run = (o_mode != MODE_SETUP);

	a_mode_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		o_mode inside {MODE_CLOCK, MODE_SETUP, MODE_ALARM}
	);

	a_inc_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n)
		!((|o_time_inc) && (|o_alarm_inc))
	);

endmodule

/* design/seg_display.sv */
`timescale 1ns/1ps

module seg_display
	import clock_pkg::*;
#(
	parameter int SCAN_DIV = 5_000
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  mode_t                 i_mode,
	input  pos_t                  i_position,
	input  field_t                i_sec,
	input  field_t                i_min,
	input  field_t                i_hou,
	input  field_t                i_alarm_sec,
	input  field_t                i_alarm_min,
	input  field_t                i_alarm_hou,
	output seg_t                  o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_seg_dp
);

	logic       scan_tick;
	logic [2:0] scan_idx;
	field_t     show_sec;
	field_t     show_min;
	field_t     show_hou;
	field_t     cur_field;
	logic [3:0] cur_digit;

	// Usual a..g table, anything else blank
	function automatic seg_t seg_decode(input logic [3:0] digit);
		seg_t seg;
		case (digit)
			4'd0:    seg = 7'h7E;
			4'd1:    seg = 7'h30;
			4'd2:    seg = 7'h6D;
			4'd3:    seg = 7'h79;
			4'd4:    seg = 7'h33;
			4'd5:    seg = 7'h5B;
			4'd6:    seg = 7'h5F;
			4'd7:    seg = 7'h70;
			4'd8:    seg = 7'h7F;
			4'd9:    seg = 7'h73;
			default: seg = 7'h00;
		endcase
		return seg;
	endfunction

	tick_gen #(
		.DIV (SCAN_DIV)
	) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	// ------------------------------
	// Digit scan
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (scan_tick) begin
			if (scan_idx == 3'(NUM_DIGITS - 1))
				scan_idx <= '0;
			else
				scan_idx <= scan_idx + 1'b1;
		end
	end

	assign o_seg_enb = ~(NUM_DIGITS'(1) << scan_idx);

	// Alarm mode shows the alarm time
	assign show_sec = (i_mode == MODE_ALARM) ? i_alarm_sec : i_sec;
	assign show_min = (i_mode == MODE_ALARM) ? i_alarm_min : i_min;
	assign show_hou = (i_mode == MODE_ALARM) ? i_alarm_hou : i_hou;

	// Even index is the ones digit, odd is the tens
	always_comb begin
		case (scan_idx[2:1])
			2'd0:    cur_field = show_sec;
			2'd1:    cur_field = show_min;
			default: cur_field = show_hou;
		endcase
		if (scan_idx[0])
			cur_digit = 4'(cur_field / 10);
		else
			cur_digit = 4'(cur_field % 10);
	end

	assign o_seg = seg_decode(cur_digit);

	// Decimal point marks the field being edited
	always_comb begin
		case (i_mode)
			MODE_SETUP: o_seg_dp = (scan_idx == {i_position, 1'b0});
			MODE_ALARM: o_seg_dp = (scan_idx == {i_position, 1'b1});
			default:    o_seg_dp = 1'b0;
		endcase
	end

	a_enb_one_cold: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb)
	);

endmodule

/* design/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 50_000_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	// Modulo-DIV counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == CW'(DIV - 1)) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Pulse at terminal count
	assign o_tick = (cnt == CW'(DIV - 1));

	// Tick is a single-cycle pulse unless dividing by one
	a_tick_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		(DIV > 1 && o_tick) |=> !o_tick
	);

endmodule

/* design/time_counter.sv */
`timescale 1ns/1ps

module time_counter
	import clock_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_tick,
	input  logic        i_run,
	input  field_mask_t i_inc,
	output field_t      o_sec,
	output field_t      o_min,
	output field_t      o_hou
);

	logic run_tick;
	logic sec_wrap;
	logic min_wrap;
	logic sec_step;
	logic min_step;
	logic hou_step;

	assign run_tick = i_run & i_tick;
	assign sec_wrap = (o_sec == field_t'(SEC_MAX));
	assign min_wrap = (o_min == field_t'(MIN_MAX));

	// Carry chain, or a single field stepped while setting
	assign sec_step = run_tick | i_inc[0];
	assign min_step = (run_tick & sec_wrap) | i_inc[1];
	assign hou_step = (run_tick & sec_wrap & min_wrap) | i_inc[2];

	// ------------------------------
	// Field registers
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec <= '0;
			o_min <= '0;
			o_hou <= '0;
		end else begin
			if (sec_step)
				o_sec <= field_step(o_sec, SEC_MAX);
			if (min_step)
				o_min <= field_step(o_min, MIN_MAX);
			if (hou_step)
				o_hou <= field_step(o_hou, HOU_MAX);
		end
	end

	a_field_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		(o_sec <= field_t'(SEC_MAX)) &&
		(o_min <= field_t'(MIN_MAX)) &&
		(o_hou <= field_t'(HOU_MAX))
	);

endmodule

/* list.f */
design/clock_pkg.sv
design/tick_gen.sv
design/key_ctrl.sv
design/time_counter.sv
design/alarm_unit.sv
design/seg_display.sv
design/clock_top.sv
testbench/clock_tb.sv

/* testbench/clock_tb.sv */
`timescale 1ns/1ps

module clock_tb
	import clock_pkg::*;
();

	localparam int TICK_DIV = 400;
	localparam int SCAN_DIV = 2;
	localparam int SW_MODE  = 0;
	localparam int SW_POS   = 1;
	localparam int SW_INC   = 2;
	localparam int SW_ALARM = 3;
	// Enough cycles for the scan to reach any digit
	localparam int DIGIT_WAIT = 2 * NUM_DIGITS * SCAN_DIV + 4;

	logic                  clk;
	logic                  rst_n;
	logic [3:0]            sw;
	seg_t                  seg;
	logic [NUM_DIGITS-1:0] seg_enb;
	logic                  seg_dp;
	logic                  alarm;

	int          errors = 0;
	int unsigned cycles = 0;
	int          cur_pos = 0;
	logic [23:0] frame_bcd;
	logic [5:0]  frame_dp;

	clock_top #(
		.TICK_DIV (TICK_DIV),
		.SCAN_DIV (SCAN_DIV)
	) u_clock_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sw_mode  (sw[SW_MODE]),
		.i_sw_pos   (sw[SW_POS]),
		.i_sw_inc   (sw[SW_INC]),
		.i_sw_alarm (sw[SW_ALARM]),
		.o_seg      (seg),
		.o_seg_enb  (seg_enb),
		.o_seg_dp   (seg_dp),
		.o_alarm    (alarm)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	// ------------------------------
	// Reference and checks
	// ------------------------------
	// Expected a..g pattern of one decimal digit
	function automatic seg_t seg_ref(input int digit);
		case (digit)
			0: return 7'h7E;
			1: return 7'h30;
			2: return 7'h6D;
			3: return 7'h79;
			4: return 7'h33;
			5: return 7'h5B;
			6: return 7'h5F;
			7: return 7'h70;
			8: return 7'h7F;
			9: return 7'h73;
			default: return 7'h00;
		endcase
	endfunction

	function automatic int seg_to_digit(input seg_t pattern);
		for (int d = 0; d < 10; d++) begin
			if (seg_ref(d) === pattern)
				return d;
		end
		return -1;
	endfunction

	// Time as six BCD digits with hours tens first
	function automatic logic [23:0] to_bcd(input int h, input int m, input int s);
		return {4'(h / 10), 4'(h % 10), 4'(m / 10), 4'(m % 10), 4'(s / 10), 4'(s % 10)};
	endfunction

	task automatic flag(input string msg);
		errors++;
		$display("Error: %s", msg);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ------------------------------
	// Stimulus and capture
	// ------------------------------
	task automatic press(input int which);
		@(posedge clk);
		sw[which] <= 1'b1;
		repeat (4) @(posedge clk);
		sw[which] <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic inc_times(input int count);
		repeat (count) press(SW_INC);
	endtask

	task automatic goto_pos(input int target);
		while (cur_pos != target) begin
			press(SW_POS);
			cur_pos = (cur_pos + 1) % 3;
		end
	endtask

	// One pass over the six digits sampled mid-cycle
	task automatic capture_frame();
		int n;
		int d;
		for (int k = 0; k < NUM_DIGITS; k++) begin
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (seg_enb !== ~(6'b1 << k) && n < DIGIT_WAIT);
			if (seg_enb !== ~(6'b1 << k))
				flag($sformatf("digit %0d never enabled on o_seg_enb", k));
			d = seg_to_digit(seg);
			if (d < 0) begin
				flag($sformatf("unknown segment pattern %h on digit %0d", seg, k));
				d = 15;
			end
			frame_bcd[k*4 +: 4] = 4'(d);
			frame_dp[k]         = seg_dp;
		end
	endtask

	// Repeat until two frames agree so a tick mid-frame does not mix times
	task automatic capture_stable();
		logic [23:0] prev_bcd;
		logic [5:0]  prev_dp;
		int          tries;
		tries = 0;
		capture_frame();
		do begin
			prev_bcd = frame_bcd;
			prev_dp  = frame_dp;
			capture_frame();
			tries++;
		end while ((frame_bcd !== prev_bcd || frame_dp !== prev_dp) && tries < 4);
		if (frame_bcd !== prev_bcd || frame_dp !== prev_dp)
			flag("display frame did not settle");
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		int          n_inc[3];
		int          n;
		int unsigned start;
		logic        seen_carry;

		rst_n = 1'b0;
		sw    = 4'b0;
		void'($urandom(32'h9ff5_3808));
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// After reset
		capture_stable();
		check("o_seg", frame_bcd, 24'h000000);
		check("o_seg_dp", frame_dp, 6'b000000);
		check("o_alarm", alarm, 1'b0);

		// Setup mode with random counts per field
		press(SW_MODE);
		for (int p = 0; p < 3; p++) begin
			goto_pos(p);
			n_inc[p] = 1 + ($urandom % 30);
			inc_times(n_inc[p]);
			capture_stable();
			check("o_seg_dp", frame_dp, 6'b1 << (2 * p));
		end
		check("o_seg", frame_bcd, to_bcd(n_inc[2] % 24, n_inc[1] % 60, n_inc[0] % 60));
		repeat (3 * TICK_DIV) @(posedge clk);
		capture_stable();
		check("o_seg", frame_bcd, to_bcd(n_inc[2] % 24, n_inc[1] % 60, n_inc[0] % 60));
		check("o_seg_dp", frame_dp, 6'b010000);

		// Set 00:59:59 and let it carry
		inc_times((24 - n_inc[2] % 24) % 24);
		goto_pos(0);
		inc_times(59 - n_inc[0] % 60);
		goto_pos(1);
		inc_times(59 - n_inc[1] % 60);
		capture_stable();
		check("o_seg", frame_bcd, 24'h005959);
		check("o_seg_dp", frame_dp, 6'b000100);
		press(SW_MODE);
		press(SW_MODE);
		start      = cycles;
		seen_carry = 1'b0;
		while (!seen_carry && (cycles - start) < 2 * TICK_DIV) begin
			capture_stable();
			if (frame_bcd === 24'h010000)
				seen_carry = 1'b1;
			else
				check("o_seg", frame_bcd, 24'h005959);
		end
		if (!seen_carry)
			flag("time did not carry to 01:00:00 in time");

		// Alarm time 01:00:05 in alarm mode
		press(SW_MODE);
		press(SW_MODE);
		goto_pos(2);
		inc_times(1);
		capture_stable();
		check("o_seg", frame_bcd, 24'h010000);
		check("o_seg_dp", frame_dp, 6'b100000);
		goto_pos(0);
		inc_times(5);
		capture_stable();
		check("o_seg", frame_bcd, 24'h010005);
		check("o_seg_dp", frame_dp, 6'b000010);

		// Alarm output
		press(SW_ALARM);
		press(SW_MODE);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (alarm !== 1'b1 && n < 8 * TICK_DIV);
		if (alarm !== 1'b1)
			flag("o_alarm did not rise at the alarm time");
		capture_stable();
		if (frame_bcd < 24'h010005) begin
			errors++;
			$display("FAIL o_seg: got %h, expected at least %h", frame_bcd, 24'h010005);
		end

		// Disable clears the level
		@(posedge clk);
		sw[SW_ALARM] <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (alarm !== 1'b0 && n < 8);
		if (alarm !== 1'b0)
			flag("o_alarm still high 8 cycles after the alarm switch press");
		@(posedge clk);
		sw[SW_ALARM] <= 1'b0;
		repeat (4) @(posedge clk);

		$display("Error count: %0d", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
